//--- upstreamPkg.sv
package upstreamPkg;

  //////////////////////////////////////////////////////////////////////
  // Word and field widths

  // Host word as seen by the PC
  localparam int PcWidth = 40;
  // Chip payload carried through untouched
  localparam int BdWidth = 34;
  // Wall time in time units
  localparam int TimeWidth = 48;
  localparam int HalfTimeWidth = TimeWidth / 2;
  // Spike filter bank outputs
  localparam int SfIdxWidth = 10;
  // State is the DSP width
  localparam int SfStateWidth = 27;

  //////////////////////////////////////////////////////////////////////
  // Field positions in the host word

  localparam int SrcBit = PcWidth - 1;
  localparam int KindBit = PcWidth - 2;
  // Zero pad between source bit and BD payload
  localparam int BdPadWidth = PcWidth - BdWidth - 1;
  // Filter index field takes whatever is left above the state
  localparam int SfIdxFieldWidth = PcWidth - SfStateWidth - 2;
  localparam int SfIdxLsb = SfStateWidth;
  localparam int SfIdxMsb = SfIdxLsb + SfIdxFieldWidth - 1;
  // Heartbeat hi/lo flag sits above the time half
  localparam int HbFlagWidth = PcWidth - HalfTimeWidth - 2;
  localparam int HbFlagLsb = HalfTimeWidth;
  localparam int HbFlagMsb = HbFlagLsb + HbFlagWidth - 1;

  //////////////////////////////////////////////////////////////////////
  // Tag values

  localparam logic SrcBd = 1'b0;
  localparam logic SrcFpga = 1'b1;
  localparam logic KindSpike = 1'b0;
  localparam logic KindHeartbeat = 1'b1;
  // Low half first, then high half
  localparam logic [HbFlagWidth-1:0] HbLo = HbFlagWidth'(0);
  localparam logic [HbFlagWidth-1:0] HbHi = HbFlagWidth'(1);

  // One packed host word
  typedef logic [PcWidth-1:0] pcWord_t;

endpackage

//--- timeKeeper.sv
`timescale 1ns/1ps

module timeKeeper #(
  parameter int ClksPerUnit = 100,
  parameter int HbEveryUnits = 1000
) (
  input  logic clk,
  input  logic reset,
  output logic [upstreamPkg::TimeWidth-1:0] timeElapsed,
  output logic hbPulse
);

  // Counter widths, kept at least one bit for tiny parameter values
  localparam int PreWidth = (ClksPerUnit > 1) ? $clog2(ClksPerUnit) : 1;
  localparam int UnitWidth = (HbEveryUnits > 1) ? $clog2(HbEveryUnits) : 1;

  logic [PreWidth-1:0] preCnt;
  logic [UnitWidth-1:0] unitCnt;
  logic unitTick;
  logic hbDue;

  // Last clock of a time unit
  assign unitTick = (preCnt == PreWidth'(ClksPerUnit - 1));
  // This unit tick lands on a heartbeat boundary
  assign hbDue = unitTick && (unitCnt == UnitWidth'(HbEveryUnits - 1));

  //////////////////////////////////////////////////////////////////////
  // Cycle prescaler

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      preCnt <= '0;
    end else if (unitTick) begin
      preCnt <= '0;
    end else begin
      preCnt <= preCnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Wall time and heartbeat unit counter

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      timeElapsed <= '0;
      unitCnt <= '0;
      hbPulse <= 1'b0;
    end else begin
      // Pulse is registered with the new time so both show in one cycle
      hbPulse <= hbDue;
      if (unitTick) begin
        timeElapsed <= timeElapsed + 1'b1;
        // Wrap at HbEveryUnits
        if (hbDue) begin
          unitCnt <= '0;
        end else begin
          unitCnt <= unitCnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- channelMerge.sv
`timescale 1ns/1ps

module channelMerge (
  input  logic clk,
  input  logic reset,
  // First input channel
  input  logic aVld,
  input  upstreamPkg::pcWord_t aData,
  output logic aAck,
  // Second input channel
  input  logic bVld,
  input  upstreamPkg::pcWord_t bData,
  output logic bAck,
  // Merged output, one register deep
  output logic outVld,
  output upstreamPkg::pcWord_t outData,
  input  logic outAck
);

  // Set when b won the most recent transfer
  logic lastB;
  logic room;
  logic grantA;
  logic grantB;
  logic load;

  //////////////////////////////////////////////////////////////////////
  // Grant and ack

  // Register is free now or drains on this edge
  assign room = !outVld || outAck;

  // b wins when alone, or when both are valid and a was served last
  assign grantB = bVld && (!aVld || !lastB);
  assign grantA = aVld && !grantB;

  // Only the winner sees ack
  assign aAck = room && grantA;
  assign bAck = room && grantB;

  assign load = aAck || bAck;

  //////////////////////////////////////////////////////////////////////
  // Output register control

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      outVld <= 1'b0;
      lastB <= 1'b0;
    end else begin
      if (load) begin
        // New word replaces or follows the drained one
        outVld <= 1'b1;
        lastB <= grantB;
      end else if (outAck) begin
        // Drained with nothing behind it
        outVld <= 1'b0;
      end
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (load) begin
      outData <= grantB ? bData : aData;
    end
  end

endmodule

//--- pcPacker.sv
`timescale 1ns/1ps

module pcPacker (
  input  logic clk,
  input  logic reset,
  // Chip traffic, passed through
  input  logic bdVld,
  input  logic [upstreamPkg::BdWidth-1:0] bdData,
  output logic bdAck,
  // Filtered spike states
  input  logic sfVld,
  input  logic [upstreamPkg::SfIdxWidth-1:0] sfFiltIdx,
  input  logic [upstreamPkg::SfStateWidth-1:0] sfFiltState,
  output logic sfAck,
  // From the time keeper
  input  logic hbPulse,
  input  logic [upstreamPkg::TimeWidth-1:0] timeElapsed,
  // Stream to the host
  output logic pcVld,
  output upstreamPkg::pcWord_t pcData,
  input  logic pcAck
);

  //////////////////////////////////////////////////////////////////////
  // Host word formats
  //
  // BD word        [ 0 | 00000 | payload 34 ]
  // Spike word     [ 1 | 0 | filter index 11 | state 27 ]
  // Heartbeat word [ 1 | 1 | hi/lo flag 14 | time half 24 ]
  //
  // Filter index is zero extended into its 11 bit field
  // Flag is 0 for the time LSBs and 1 for the time MSBs

  typedef enum logic [1:0] {
    HbIdle,
    HbSendLo,
    HbSendHi
  } hbState_t;

  upstreamPkg::pcWord_t bdWord;
  upstreamPkg::pcWord_t sfWord;
  upstreamPkg::pcWord_t hbWord;
  logic hbVld;
  logic hbAck;

  hbState_t hbState;
  hbState_t hbNext;
  // Time captured at the pulse
  logic [upstreamPkg::TimeWidth-1:0] hbTime;
  logic [upstreamPkg::HalfTimeWidth-1:0] hbHalf;
  logic [upstreamPkg::HbFlagWidth-1:0] hbFlag;

  // Inner merge output feeds the root merge
  logic innerVld;
  upstreamPkg::pcWord_t innerData;
  logic innerAck;

  //////////////////////////////////////////////////////////////////////
  // BD tagging

  assign bdWord = {upstreamPkg::SrcBd, upstreamPkg::BdPadWidth'(0), bdData};

  //////////////////////////////////////////////////////////////////////
  // Spike tagging

  assign sfWord = {upstreamPkg::SrcFpga, upstreamPkg::KindSpike,
                   upstreamPkg::SfIdxFieldWidth'(sfFiltIdx), sfFiltState};

  //////////////////////////////////////////////////////////////////////
  // Heartbeat FSM
  // Latches the time on a pulse, then sends low and high halves in turn

  always_comb begin
    hbNext = hbState;
    unique case (hbState)
      HbIdle:
        if (hbPulse) begin
          hbNext = HbSendLo;
        end
      HbSendLo:
        if (hbAck) begin
          hbNext = HbSendHi;
        end
      HbSendHi:
        if (hbAck) begin
          hbNext = HbIdle;
        end
      default:
        hbNext = HbIdle;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      hbState <= HbIdle;
    end else begin
      hbState <= hbNext;
    end
  end

  // Pulses outside idle are dropped, the capture waits for idle
  always_ff @(posedge clk) begin
    if (hbState == HbIdle && hbPulse) begin
      hbTime <= timeElapsed;
    end
  end

  assign hbVld = (hbState != HbIdle);
  assign hbFlag = (hbState == HbSendHi) ? upstreamPkg::HbHi : upstreamPkg::HbLo;
  assign hbHalf = (hbState == HbSendHi)
                ? hbTime[upstreamPkg::TimeWidth-1:upstreamPkg::HalfTimeWidth]
                : hbTime[upstreamPkg::HalfTimeWidth-1:0];
  assign hbWord = {upstreamPkg::SrcFpga, upstreamPkg::KindHeartbeat, hbFlag, hbHalf};

  //////////////////////////////////////////////////////////////////////
  // Merge tree
  // Spike and heartbeat share the inner merge, BD joins at the root

  channelMerge hbSfMerge (
    .clk     (clk),
    .reset   (reset),
    .aVld    (sfVld),
    .aData   (sfWord),
    .aAck    (sfAck),
    .bVld    (hbVld),
    .bData   (hbWord),
    .bAck    (hbAck),
    .outVld  (innerVld),
    .outData (innerData),
    .outAck  (innerAck)
  );

  channelMerge rootMerge (
    .clk     (clk),
    .reset   (reset),
    .aVld    (bdVld),
    .aData   (bdWord),
    .aAck    (bdAck),
    .bVld    (innerVld),
    .bData   (innerData),
    .bAck    (innerAck),
    .outVld  (pcVld),
    .outData (pcData),
    .outAck  (pcAck)
  );

endmodule

//--- upstreamTop.sv
`timescale 1ns/1ps

module upstreamTop #(
  // Clock cycles per time unit
  parameter int ClksPerUnit = 100,
  // Time units between heartbeats
  parameter int HbEveryUnits = 1000
) (
  input  logic clk,
  input  logic reset,
  // Chip traffic
  input  logic bdVld,
  input  logic [upstreamPkg::BdWidth-1:0] bdData,
  output logic bdAck,
  // Filtered spikes
  input  logic sfVld,
  input  logic [upstreamPkg::SfIdxWidth-1:0] sfFiltIdx,
  input  logic [upstreamPkg::SfStateWidth-1:0] sfFiltState,
  output logic sfAck,
  // Host side
  output logic pcVld,
  output upstreamPkg::pcWord_t pcData,
  input  logic pcAck
);

  logic [upstreamPkg::TimeWidth-1:0] timeElapsed;
  logic hbPulse;

  // Wall time and heartbeat request
  timeKeeper #(
    .ClksPerUnit  (ClksPerUnit),
    .HbEveryUnits (HbEveryUnits)
  ) timeKeeperInst (
    .clk         (clk),
    .reset       (reset),
    .timeElapsed (timeElapsed),
    .hbPulse     (hbPulse)
  );

  // Tagging and merge into the host stream
  pcPacker pcPackerInst (
    .clk         (clk),
    .reset       (reset),
    .bdVld       (bdVld),
    .bdData      (bdData),
    .bdAck       (bdAck),
    .sfVld       (sfVld),
    .sfFiltIdx   (sfFiltIdx),
    .sfFiltState (sfFiltState),
    .sfAck       (sfAck),
    .hbPulse     (hbPulse),
    .timeElapsed (timeElapsed),
    .pcVld       (pcVld),
    .pcData      (pcData),
    .pcAck       (pcAck)
  );

endmodule

//--- pcPackerTb.sv
`timescale 1ns/1ps

module pcPackerTb;

  localparam int ClksPerUnit = 4;
  localparam int HbEveryUnits = 8;
  // Clock cycles between heartbeat pulses
  localparam int HbCycles = ClksPerUnit * HbEveryUnits;
  localparam logic IsBd = 1'b0;
  localparam logic IsSf = 1'b1;

  typedef struct packed {
    logic src;
    // Spike entries put the filter index above the 27 bit state
    logic [36:0] payload;
    logic [3:0] gap;
  } stim_t;

  //////////////////////////////////////////////////////////////////////
  // Stimulus table with columns source, payload and idle gap in cycles

  localparam int NumStim = 28;
  localparam stim_t StimTable [NumStim] = '{
    '{IsBd, 37'h00_0000_0001, 4'd0}, '{IsSf, 37'h00_0800_0001, 4'd2},
    '{IsBd, 37'h03_FFFF_FFFF, 4'd1}, '{IsSf, 37'h1F_FFFF_FFFF, 4'd0},
    '{IsBd, 37'h01_2345_6789, 4'd5}, '{IsSf, 37'h12_3456_789A, 4'd3},
    '{IsBd, 37'h02_AAAA_5555, 4'd0}, '{IsSf, 37'h0A_5A5A_5A5A, 4'd4},
    '{IsBd, 37'h00_DEAD_BEEF, 4'd0}, '{IsSf, 37'h15_5555_5555, 4'd0},
    '{IsBd, 37'h03_0000_0000, 4'd1}, '{IsSf, 37'h00_07FF_FFFF, 4'd0},
    '{IsBd, 37'h00_CAFE_F00D, 4'd0}, '{IsSf, 37'h1F_F800_0000, 4'd2},
    '{IsBd, 37'h01_0F0F_0F0F, 4'd0}, '{IsSf, 37'h0C_3C3C_3C3C, 4'd1},
    '{IsBd, 37'h00_0000_1000, 4'd0}, '{IsSf, 37'h00_1000_0010, 4'd0},
    '{IsBd, 37'h00_0000_2000, 4'd0}, '{IsSf, 37'h00_1800_0020, 4'd0},
    '{IsBd, 37'h00_0000_3000, 4'd0}, '{IsSf, 37'h00_2000_0030, 4'd0},
    '{IsBd, 37'h00_0000_4000, 4'd0}, '{IsSf, 37'h00_2800_0040, 4'd0},
    '{IsBd, 37'h00_0000_5000, 4'd0}, '{IsSf, 37'h00_3000_0050, 4'd0},
    '{IsBd, 37'h00_0000_6000, 4'd0}, '{IsSf, 37'h00_3800_0060, 4'd0}
  };

  // Phase table with columns first entry, entry count and ack percent
  localparam int NumPhases = 3;
  localparam int FairPhase = 2;
  localparam int PhaseFirst [NumPhases] = '{0, 8, 16};
  localparam int PhaseCount [NumPhases] = '{8, 8, 12};
  localparam int PhaseAckPct [NumPhases] = '{100, 25, 100};
  string phaseName [NumPhases] = '{"passThrough", "backPressure", "fairMerge"};

  logic clk;
  logic reset;
  logic bdVld;
  logic [upstreamPkg::BdWidth-1:0] bdData;
  logic bdAck;
  logic sfVld;
  logic [upstreamPkg::SfIdxWidth-1:0] sfFiltIdx;
  logic [upstreamPkg::SfStateWidth-1:0] sfFiltState;
  logic sfAck;
  logic pcVld;
  upstreamPkg::pcWord_t pcData;
  logic pcAck;

  // Received words per source, in arrival order
  upstreamPkg::pcWord_t bdGot [$];
  upstreamPkg::pcWord_t sfGot [$];
  logic [31:0] lfsr = 32'h6bb2;
  int ackPct = 100;
  int cycleCount = 0;
  // Consecutive cycles with pcAck high
  int ackHighRun = 0;
  int checkCount = 0;
  int errorCount = 0;
  int testChecks = 0;
  int testErrors = 0;
  int hbPairs = 0;
  int firstHbCycle = -1;
  logic hbHaveLo = 1'b0;
  logic [upstreamPkg::HalfTimeWidth-1:0] hbLoHalf = '0;
  logic [upstreamPkg::TimeWidth-1:0] prevHbTime = '0;
  // Fairness counters stay at -1 until the first BD or spike word of the phase
  logic fairOn = 1'b0;
  logic bdBusy = 1'b0;
  logic sfBusy = 1'b0;
  int sinceBd = -1;
  int sinceSf = -1;

  upstreamTop #(
    .ClksPerUnit  (ClksPerUnit),
    .HbEveryUnits (HbEveryUnits)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .bdVld       (bdVld),
    .bdData      (bdData),
    .bdAck       (bdAck),
    .sfVld       (sfVld),
    .sfFiltIdx   (sfFiltIdx),
    .sfFiltState (sfFiltState),
    .sfAck       (sfAck),
    .pcVld       (pcVld),
    .pcData      (pcData),
    .pcAck       (pcAck)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Cycles since reset release
  always @(posedge clk) begin
    if (!reset) begin
      cycleCount <= cycleCount + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random back-pressure

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    // Right shift Galois form with taps 32 22 2 1
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic takeBit();
    logic b;
    b = lfsr[0];
    lfsr = lfsrStep(lfsr);
    return b;
  endfunction

  function automatic logic drawAck(input int pct);
    logic [7:0] r;
    int i;
    for (i = 0; i < 8; i++) begin
      r[i] = takeBit();
    end
    return (int'(r) * 100) < (pct * 256);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking and reporting

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checkCount++;
    testChecks++;
    if (expected !== actual) begin
      errorCount++;
      testErrors++;
      $display("ERR time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic flagFailure(input string msg);
    checkCount++;
    testChecks++;
    errorCount++;
    testErrors++;
    $display("Failure at time %0t: %s", $time, msg);
  endtask

  task automatic finishTest(input string name);
    $display("test %s done: %0d checks, %0d errors", name, testChecks, testErrors);
    testChecks = 0;
    testErrors = 0;
  endtask

  // Time must be a nonzero multiple of HbEveryUnits and move forward
  task automatic checkHeartbeat(input logic [upstreamPkg::TimeWidth-1:0] t);
    if (t == 0 || (t % HbEveryUnits) != 0) begin
      flagFailure($sformatf("heartbeat time %0d is not a nonzero multiple of %0d",
                            t, HbEveryUnits));
    end else if (prevHbTime != 0 && ackHighRun >= 2 * HbCycles) begin
      // No pulse can have been dropped during a long ack-high run
      checkValue("hbTime", 64'(prevHbTime + HbEveryUnits), 64'(t));
    end else if (t <= prevHbTime) begin
      flagFailure($sformatf("heartbeat time %0d did not increase past %0d", t, prevHbTime));
    end
    prevHbTime = t;
  endtask

  // Decode one accepted word by its tag bits
  task automatic takeWord(input upstreamPkg::pcWord_t w);
    logic [upstreamPkg::HbFlagWidth-1:0] flag;
    logic isBdWord;
    logic isSfWord;
    flag = w[upstreamPkg::HbFlagMsb:upstreamPkg::HbFlagLsb];
    isBdWord = (w[upstreamPkg::SrcBit] == upstreamPkg::SrcBd);
    isSfWord = !isBdWord && (w[upstreamPkg::KindBit] == upstreamPkg::KindSpike);
    if (isBdWord) begin
      bdGot.push_back(w);
    end else if (isSfWord) begin
      sfGot.push_back(w);
    end else if (!hbHaveLo) begin
      // Low half opens a pair
      if (firstHbCycle < 0) begin
        firstHbCycle = cycleCount;
      end
      checkValue("hbFlag", 64'(0), 64'(flag));
      hbLoHalf = w[upstreamPkg::HalfTimeWidth-1:0];
      hbHaveLo = 1'b1;
    end else begin
      checkValue("hbFlag", 64'(1), 64'(flag));
      hbHaveLo = 1'b0;
      hbPairs++;
      checkHeartbeat({w[upstreamPkg::HalfTimeWidth-1:0], hbLoHalf});
    end
    // Both counters start with the first BD or spike word of the phase
    if (sinceBd < 0 && (isBdWord || isSfWord)) begin
      sinceBd = 0;
      sinceSf = 0;
    end
    // Output words since each source was last served
    if (isBdWord) begin
      sinceBd = 0;
    end else if (sinceBd >= 0) begin
      sinceBd++;
    end
    if (isSfWord) begin
      sinceSf = 0;
    end else if (sinceSf >= 0) begin
      sinceSf++;
    end
    if (fairOn && bdBusy && sfBusy && sinceBd == 4) begin
      flagFailure("BD source went four output words without a word of its own");
    end
    if (fairOn && bdBusy && sfBusy && sinceSf == 4) begin
      flagFailure("spike source went four output words without a word of its own");
    end
  endtask

  // Ack is drawn on the falling edge and the output sampled 1 ns later
  initial begin
    pcAck = 1'b1;
    forever begin
      @(negedge clk);
      pcAck = drawAck(ackPct);
      #1;
      if (pcAck) begin
        ackHighRun++;
      end else begin
        ackHighRun = 0;
      end
      if (!reset && pcVld && pcAck) begin
        takeWord(pcData);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drivers are entered on a falling edge and left on one

  task automatic sendBd(input logic [36:0] payload, input int gap);
    logic done;
    repeat (gap) @(negedge clk);
    bdVld = 1'b1;
    bdData = payload[33:0];
    done = 1'b0;
    while (!done) begin
      #1;
      done = bdAck;
      @(negedge clk);
    end
    bdVld = 1'b0;
  endtask

  task automatic sendSf(input logic [36:0] payload, input int gap);
    logic done;
    repeat (gap) @(negedge clk);
    sfVld = 1'b1;
    sfFiltIdx = payload[36:27];
    sfFiltState = payload[26:0];
    done = 1'b0;
    while (!done) begin
      #1;
      done = sfAck;
      @(negedge clk);
    end
    sfVld = 1'b0;
  endtask

  // Applies the phase entries of one source in table order
  task automatic driveSource(input int p, input logic src);
    int i;
    for (i = PhaseFirst[p]; i < PhaseFirst[p] + PhaseCount[p]; i++) begin
      if (StimTable[i].src == src && src == IsBd) begin
        sendBd(StimTable[i].payload, int'(StimTable[i].gap));
      end else if (StimTable[i].src == src) begin
        sendSf(StimTable[i].payload, int'(StimTable[i].gap));
      end
    end
    if (src == IsBd) begin
      bdBusy = 1'b0;
    end else begin
      sfBusy = 1'b0;
    end
  endtask

  task automatic runPhase(input int p);
    stim_t e;
    upstreamPkg::pcWord_t got;
    int nBd;
    int nSf;
    int i;
    nBd = 0;
    nSf = 0;
    for (i = PhaseFirst[p]; i < PhaseFirst[p] + PhaseCount[p]; i++) begin
      if (StimTable[i].src == IsBd) begin
        nBd++;
      end else begin
        nSf++;
      end
    end
    ackPct = PhaseAckPct[p];
    fairOn = (p == FairPhase);
    sinceBd = -1;
    sinceSf = -1;
    bdBusy = 1'b1;
    sfBusy = 1'b1;
    @(negedge clk);
    fork
      driveSource(p, IsBd);
      driveSource(p, IsSf);
    join
    fairOn = 1'b0;
    // Drain, then give late duplicates a chance to show
    while (bdGot.size() < nBd || sfGot.size() < nSf) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    checkValue("bdCount", 64'(nBd), 64'(bdGot.size()));
    checkValue("sfCount", 64'(nSf), 64'(sfGot.size()));
    for (i = PhaseFirst[p]; i < PhaseFirst[p] + PhaseCount[p]; i++) begin
      e = StimTable[i];
      if (e.src == IsBd && bdGot.size() > 0) begin
        got = bdGot.pop_front();
        // Source 0, five zero bits, payload
        checkValue("pcData", 64'({1'b0, 5'b00000, e.payload[33:0]}), 64'(got));
      end else if (e.src == IsSf && sfGot.size() > 0) begin
        got = sfGot.pop_front();
        // Source 1, kind 0, zero extended index, state
        checkValue("pcData", 64'({2'b10, 1'b0, e.payload[36:27], e.payload[26:0]}),
                   64'(got));
      end
    end
    bdGot.delete();
    sfGot.delete();
    finishTest(phaseName[p]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int p;
    reset = 1'b1;
    bdVld = 1'b0;
    bdData = '0;
    sfVld = 1'b0;
    sfFiltIdx = '0;
    sfFiltState = '0;
    repeat (2) @(posedge clk);
    #1;
    checkValue("pcVld", 64'(0), 64'(pcVld));
    @(negedge clk);
    reset = 1'b0;
    #1;
    checkValue("pcVld", 64'(0), 64'(pcVld));
    // Wait for two heartbeat pairs on the idle link
    while (hbPairs < 2) begin
      @(negedge clk);
    end
    if (firstHbCycle < HbCycles) begin
      flagFailure($sformatf("first heartbeat came %0d cycles after reset", firstHbCycle));
    end
    finishTest("reset");
    for (p = 0; p < NumPhases; p++) begin
      runPhase(p);
    end
    $display("all tests: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Limit from table length and the longest gap
  initial begin
    int maxGap;
    int cycleLimit;
    int i;
    maxGap = 0;
    for (i = 0; i < NumStim; i++) begin
      if (int'(StimTable[i].gap) > maxGap) begin
        maxGap = int'(StimTable[i].gap);
      end
    end
    cycleLimit = NumStim * (maxGap + 1) * 8 + 500;
    wait (cycleCount > cycleLimit);
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- project.f
upstreamPkg.sv
timeKeeper.sv
channelMerge.sv
pcPacker.sv
upstreamTop.sv
pcPackerTb.sv

//--- Makefile
# Verilator build and run for the upstream host link

VERILATOR ?= verilator
TOP ?= pcPackerTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= *** PASSED ***

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the simulation prints the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
